/* verilog.f */
+incdir+rtl
rtl/audio_pkg.sv
rtl/audioRegisterBank.sv
rtl/sampleFetcher.sv
rtl/stereoMixer.sv
rtl/i2sTransmitter.sv
rtl/audioSubsystem.sv
verif/audio_properties.sv
verif/audio_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the audio engine simulation with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module audio_tb -o audio_sim
./obj_dir/audio_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "Simulation failed" sim.log; then
    exit 1
fi
if ! grep -q "Simulation passed" sim.log; then
    exit 1
fi
exit 0

/* verif/audio_tb.sv */
// Testbench for the audio engine with random memory, APB programming and I2S checking
`include "audio_config.svh"

module audio_tb;

    localparam logic [31:0] lfsrSeed  = 32'h64b6_cbb1;
    localparam int          numFrames = 40;
    localparam int          memWords  = 512;
    localparam int          nv        = `AUDIO_NUM_VOICES;

    logic        aclk;
    logic        aresetn;
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic [31:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [15:0] rdata;
    logic        rvalid;
    logic        rready;
    logic        bclk;
    logic        lrclk;
    logic        sdata;

    logic [15:0]           mem [memWords];
    logic [31:0]           lfsrState = lfsrSeed;
    logic [31:0]           mStart [nv];
    logic [15:0]           mLen [nv];
    logic [15:0]           mPos [nv];
    audio_pkg::voiceCtrl_t mCtrl [nv];
    audio_pkg::sample_t    mSample [nv];
    audio_pkg::sample_t    expLeft [$];
    audio_pkg::sample_t    expRight [$];
    int                    checkedFrames = 0;
    logic                  runStarted = 1'b0;

    audioSubsystem u_dut (
        .i_aclk(aclk), .i_aresetn(aresetn), .i_paddr(paddr), .i_psel(psel),
        .i_penable(penable), .i_pwrite(pwrite), .i_pwdata(pwdata), .o_prdata(prdata),
        .o_pready(pready), .o_pslverr(pslverr), .o_araddr(araddr), .o_arvalid(arvalid),
        .i_arready(arready), .i_rdata(rdata), .i_rvalid(rvalid), .o_rready(rready),
        .o_bclk(bclk), .o_lrclk(lrclk), .o_sdata(sdata)
    );

    always #4 aclk = ~aclk;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = {lfsrState[30:0],
                         lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0]};
            v = {v[30:0], lfsrState[0]};
        end
        return v;
    endfunction

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic checkSample(input string name, input audio_pkg::sample_t got,
                               input audio_pkg::sample_t exp);
        if (got !== exp) begin
            failRun($sformatf("FAILED time %0t %s got %0d expected %0d", $time, name, got, exp));
        end
    endtask

    task automatic checkReg(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            failRun($sformatf("FAILED time %0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic nextCycle();
        @(posedge aclk);
        #1;
    endtask

    task automatic apbAccess(input logic wr, input audio_pkg::voiceIdx_t v, input logic [2:0] idx,
                             input logic [31:0] wdata, output logic [31:0] rd, output logic err);
        int waits;
        waits = 0;
        nextCycle();
        paddr  = {v, idx, 2'b00};
        pwrite = wr;
        pwdata = wdata;
        psel   = 1'b1;
        nextCycle();
        penable = 1'b1;
        @(negedge aclk);
        while (!pready) begin
            waits++;
            if (waits > 4) failRun("APB transfer never completed");
            @(negedge aclk);
        end
        rd  = prdata;
        err = pslverr;
        nextCycle();
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic writeReg(input audio_pkg::voiceIdx_t v, input logic [2:0] idx,
                            input logic [31:0] data, input logic expErr);
        logic [31:0] rd;
        logic        err;
        apbAccess(1'b1, v, idx, data, rd, err);
        checkReg("pslverr", {31'd0, err}, {31'd0, expErr});
        if (!expErr) begin
            case (idx)
                3'd0:    mStart[v] = {data[31:1], 1'b0};
                3'd1:    mLen[v]   = data[15:0];
                default: mCtrl[v]  = audio_pkg::voiceCtrl_t'(data[3:0]);
            endcase
        end
    endtask

    task automatic readReg(input audio_pkg::voiceIdx_t v, input logic [2:0] idx);
        logic [31:0] rd;
        logic [31:0] exp;
        logic        err;
        case (idx)
            3'd0:    exp = mStart[v];
            3'd1:    exp = {16'd0, mLen[v]};
            3'd2:    exp = {28'd0, mCtrl[v]};
            3'd3:    exp = {15'd0, mCtrl[v].play, mPos[v]};
            default: exp = '0;
        endcase
        apbAccess(1'b0, v, idx, 32'd0, rd, err);
        checkReg("pslverr", {31'd0, err}, {31'd0, idx[2]});
        checkReg("prdata", rd, exp);
    endtask

    task automatic setVoice(input int v, input logic [31:0] start, input logic [31:0] len,
                            input logic [31:0] ctrl);
        writeReg(audio_pkg::voiceIdx_t'(v), 3'd0, start, 1'b0);
        writeReg(audio_pkg::voiceIdx_t'(v), 3'd1, len, 1'b0);
        writeReg(audio_pkg::voiceIdx_t'(v), 3'd2, ctrl, 1'b0);
    endtask

    // One fetch per playing voice at frame start
    task automatic scanFrame();
        logic [31:0] addr;
        logic [15:0] nextPos;
        for (int v = 0; v < nv; v++) begin
            if (mCtrl[v].play) begin
                addr       = mStart[v] + 32'(mPos[v]) * 32'd2;
                mSample[v] = mem[addr[9:1]];
                nextPos    = mPos[v] + 16'd1;
                mPos[v]    = (nextPos >= mLen[v]) ? 16'd0 : nextPos;
                if (nextPos >= mLen[v] && !mCtrl[v].loop) begin
                    mCtrl[v].play = 1'b0;
                    mSample[v]    = '0;
                end
            end else begin
                mSample[v] = '0;
            end
        end
    endtask

    function automatic audio_pkg::sample_t mixSide(input logic rightSide);
        int acc;
        acc = 0;
        for (int v = 0; v < nv; v++) begin
            if (mCtrl[v].mono || mCtrl[v].right == rightSide) acc += int'(mSample[v]);
        end
        if (acc > 32767) acc = 32767;
        if (acc < -32768) acc = -32768;
        return audio_pkg::sample_t'(acc);
    endfunction

    initial begin
        logic [31:0] r;
        aclk    = 0;
        aresetn = 0;
        paddr   = '0;
        psel    = 0;
        penable = 0;
        pwrite  = 0;
        pwdata  = '0;
        arready = 0;
        rvalid  = 0;
        rdata   = '0;
        for (int i = 0; i < memWords; i++) mem[i] = randBits(16);
        for (int i = 0; i < 16; i++) begin
            mem[400 + i] = 16'h7000 + 16'(i);   // Loud positive block
            mem[432 + i] = 16'h9000 - 16'(i);   // Loud negative block
        end
        for (int v = 0; v < nv; v++) begin
            mStart[v]  = '0;
            mLen[v]    = '0;
            mPos[v]    = '0;
            mCtrl[v]   = '0;
            mSample[v] = '0;
        end
        repeat (5) @(posedge aclk);
        #1 aresetn = 1'b1;

        for (int v = 0; v < nv; v++) begin
            writeReg(audio_pkg::voiceIdx_t'(v), 3'd0, randBits(32), 1'b0);
            writeReg(audio_pkg::voiceIdx_t'(v), 3'd1, randBits(32), 1'b0);
            r = randBits(3);    // Play stays off
            writeReg(audio_pkg::voiceIdx_t'(v), 3'd2, r, 1'b0);
            writeReg(audio_pkg::voiceIdx_t'(v), 3'(4 + randBits(2)), randBits(32), 1'b1);
            writeReg(audio_pkg::voiceIdx_t'(v), 3'd3, randBits(32), 1'b1);
            readReg(audio_pkg::voiceIdx_t'(v), 3'(4 + randBits(2)));
            for (int idx = 0; idx < 4; idx++) readReg(audio_pkg::voiceIdx_t'(v), 3'(idx));
        end

        expLeft.push_back('0);
        expRight.push_back('0);
        runStarted = 1'b1;
        for (int f = 0; f < numFrames; f++) begin
            @(negedge lrclk);
            scanFrame();
            @(posedge lrclk);   // Fetch scan long finished here
            if (f == 1) setVoice(0, randBits(8) << 1, 5, 4'b1010);
            if (f == 9) begin
                for (int v = 1; v < 4; v++) setVoice(v, randBits(9) << 1, 3 + randBits(2),
                                                     12 + randBits(2));
            end
            if (f == 20) begin
                for (int v = 1; v < 4; v++) writeReg(audio_pkg::voiceIdx_t'(v), 3'd2, 0, 1'b0);
                for (int v = 4; v < 8; v++) setVoice(v, 800, 8, 4'b1110);
            end
            if (f == 28) begin
                for (int v = 4; v < 8; v++) writeReg(audio_pkg::voiceIdx_t'(v), 3'd0, 864, 1'b0);
            end
            if (f == 34) begin
                for (int v = 4; v < 8; v++) writeReg(audio_pkg::voiceIdx_t'(v), 3'd2, 0, 1'b0);
            end
            readReg(audio_pkg::voiceIdx_t'(f % nv), 3'd3);
            expLeft.push_back(mixSide(1'b0));
            expRight.push_back(mixSide(1'b1));
        end
        repeat (2) @(negedge lrclk);
        if (checkedFrames >= numFrames) begin
            $display("Simulation passed");
            $finish;
        end else begin
            failRun("too few I2S frames were decoded");
        end
    end

    // AXI-Lite read slave with random stalls
    initial begin
        logic [31:0] addr;
        forever begin
            @(negedge aclk);
            if (arvalid) begin
                addr = araddr;
                nextCycle();
                repeat (randBits(2)) nextCycle();
                arready = 1'b1;
                nextCycle();
                arready = 1'b0;
                checkReg("rready", {31'd0, rready}, 32'd1);    // Up right after the address beat
                repeat (randBits(2)) nextCycle();
                rdata  = mem[addr[9:1]];
                rvalid = 1'b1;
                checkReg("rready", {31'd0, rready}, 32'd1);
                nextCycle();
                rvalid = 1'b0;
                checkReg("rready", {31'd0, rready}, 32'd0);    // Down after the data beat
            end
        end
    end

    // I2S decoder giving one stereo word pair per frame
    initial begin
        audio_pkg::sample_t l;
        audio_pkg::sample_t r;
        wait (runStarted);
        @(negedge lrclk);
        forever begin
            repeat (16) begin
                @(posedge bclk);
                l = {l[14:0], sdata};
            end
            repeat (16) begin
                @(posedge bclk);
                r = {r[14:0], sdata};
            end
            if (expLeft.size() == 0) failRun("decoded a frame with no expected value");
            checkSample("left", l, expLeft.pop_front());
            checkSample("right", r, expRight.pop_front());
            checkedFrames++;
        end
    end

    initial begin
        #((numFrames + 12) * 256 * 8);
        failRun("watchdog timeout, run did not finish");
    end

endmodule

/* verif/audio_properties.sv */
// Handshake and fetch timing checks bound into the audio subsystem
module audio_properties (
    input logic        i_aclk,
    input logic        i_aresetn,
    input logic        i_psel,
    input logic        i_penable,
    input logic        o_pready,
    input logic [31:0] o_araddr,
    input logic        o_arvalid,
    input logic        i_arready,
    input logic        o_rready,
    input logic        frameStrobe
);

    // Address channel holds until accepted
    arHold: assert property (@(posedge i_aclk) disable iff (!i_aresetn)
        o_arvalid && !i_arready |=> o_arvalid && $stable(o_araddr))
        else $error("arvalid or araddr changed before arready");

    // One wait state, so pready only in the second access cycle
    preadyLate: assert property (@(posedge i_aclk) disable iff (!i_aresetn)
        o_pready |-> i_psel && i_penable && $past(i_psel && i_penable) && !$past(i_penable, 2))
        else $error("pready outside the second access cycle");

    preadyOnTime: assert property (@(posedge i_aclk) disable iff (!i_aresetn)
        i_psel && i_penable && !$past(i_penable) |=> o_pready)
        else $error("pready missing in the second access cycle");

    fetchIdle: assert property (@(posedge i_aclk) disable iff (!i_aresetn)
        frameStrobe |-> !o_arvalid && !o_rready)
        else $error("fetch still busy at frame strobe");

endmodule

bind audioSubsystem audio_properties u_props (.*);

/* rtl/audioSubsystem.sv */
// Eight-voice sample playback engine with APB control, AXI-Lite reads and I2S output
`include "audio_config.svh"

module audioSubsystem (
    input  logic                          i_aclk,
    input  logic                          i_aresetn,
    input  logic [7:0]                    i_paddr,
    input  logic                          i_psel,
    input  logic                          i_penable,
    input  logic                          i_pwrite,
    input  logic [31:0]                   i_pwdata,
    output logic [31:0]                   o_prdata,
    output logic                          o_pready,
    output logic                          o_pslverr,
    output logic [31:0]                   o_araddr,
    output logic                          o_arvalid,
    input  logic                          i_arready,
    input  logic [`AUDIO_SAMPLE_W-1:0]    i_rdata,
    input  logic                          i_rvalid,
    output logic                          o_rready,
    output logic                          o_bclk,
    output logic                          o_lrclk,
    output logic                          o_sdata
);

    localparam int numVoices = `AUDIO_NUM_VOICES;
    localparam int sampleW   = `AUDIO_SAMPLE_W;

    logic [numVoices*32-1:0]      voiceStart;
    logic [numVoices*16-1:0]      voiceLength;
    logic [numVoices*4-1:0]       voiceCtrl;
    logic [numVoices-1:0]         voiceStop;
    logic [numVoices*16-1:0]      voicePos;
    logic [numVoices*sampleW-1:0] samples;
    audio_pkg::sample_t           mixLeft;
    audio_pkg::sample_t           mixRight;
    logic                         frameStrobe;

    audioRegisterBank u_regBank (
        .i_aclk        (i_aclk),
        .i_aresetn     (i_aresetn),
        .i_paddr       (i_paddr),
        .i_psel        (i_psel),
        .i_penable     (i_penable),
        .i_pwrite      (i_pwrite),
        .i_pwdata      (i_pwdata),
        .o_prdata      (o_prdata),
        .o_pready      (o_pready),
        .o_pslverr     (o_pslverr),
        .i_voiceStop   (voiceStop),
        .i_voicePos    (voicePos),
        .o_voiceStart  (voiceStart),
        .o_voiceLength (voiceLength),
        .o_voiceCtrl   (voiceCtrl)
    );

    sampleFetcher u_fetcher (
        .i_aclk        (i_aclk),
        .i_aresetn     (i_aresetn),
        .i_frameStrobe (frameStrobe),
        .i_voiceStart  (voiceStart),
        .i_voiceLength (voiceLength),
        .i_voiceCtrl   (voiceCtrl),
        .o_voiceStop   (voiceStop),
        .o_voicePos    (voicePos),
        .o_araddr      (o_araddr),
        .o_arvalid     (o_arvalid),
        .i_arready     (i_arready),
        .i_rdata       (i_rdata),
        .i_rvalid      (i_rvalid),
        .o_rready      (o_rready),
        .o_samples     (samples)
    );

    stereoMixer u_mixer (
        .i_aclk      (i_aclk),
        .i_aresetn   (i_aresetn),
        .i_samples   (samples),
        .i_voiceCtrl (voiceCtrl),
        .o_left      (mixLeft),
        .o_right     (mixRight)
    );

    i2sTransmitter u_i2s (
        .i_aclk        (i_aclk),
        .i_aresetn     (i_aresetn),
        .i_left        (mixLeft),
        .i_right       (mixRight),
        .o_frameStrobe (frameStrobe),
        .o_bclk        (o_bclk),
        .o_lrclk       (o_lrclk),
        .o_sdata       (o_sdata)
    );

endmodule

/* rtl/i2sTransmitter.sv */
// I2S serializer deriving bit clock, word select and frame strobe from aclk
`include "audio_config.svh"

module i2sTransmitter (
    input  logic               i_aclk,
    input  logic               i_aresetn,
    input  audio_pkg::sample_t i_left,
    input  audio_pkg::sample_t i_right,
    output logic               o_frameStrobe,
    output logic               o_bclk,
    output logic               o_lrclk,
    output logic               o_sdata
);

    localparam int sampleW = `AUDIO_SAMPLE_W;
    localparam int div     = `AUDIO_BCLK_DIV;
    localparam int divW    = $clog2(div + 1);
    localparam int bitW    = $clog2(2 * sampleW);

    logic [divW-1:0]      divCnt;
    logic [bitW-1:0]      bitCnt;
    logic [bitW-1:0]      nextBit;
    logic [2*sampleW-1:0] shiftReg;
    logic                 divWrap;
    logic                 bclkFall;
    logic                 frameStart;

    assign divWrap    = (divCnt == divW'(div - 1));
    assign bclkFall   = divWrap & o_bclk;           // Data and word select move here
    assign nextBit    = bitCnt + 1'b1;
    assign frameStart = bclkFall & (nextBit == '0);

    always_ff @(posedge i_aclk) begin
        if (!i_aresetn) begin
            divCnt        <= '0;
            o_bclk        <= 1'b0;
            bitCnt        <= '1;    // Last right bit, so the first fall opens a frame
            o_lrclk       <= 1'b0;
            o_frameStrobe <= 1'b0;
        end else begin
            o_frameStrobe <= frameStart;
            divCnt        <= divWrap ? '0 : divCnt + 1'b1;
            if (divWrap) begin
                o_bclk <= ~o_bclk;
            end
            if (bclkFall) begin
                bitCnt  <= nextBit;
                o_lrclk <= nextBit[bitW-1];     // Low for left, high for right
            end
        end
    end

    // Left-justified, MSB leaves together with the word-select edge
    always_ff @(posedge i_aclk) begin
        if (!i_aresetn) begin
            o_sdata <= 1'b0;
        end else if (frameStart) begin
            o_sdata <= i_left[sampleW-1];
        end else if (bclkFall) begin
            o_sdata <= shiftReg[2*sampleW-1];
        end
    end

    always_ff @(posedge i_aclk) begin
        if (frameStart) begin
            shiftReg <= {i_left[sampleW-2:0], i_right, 1'b0};
        end else if (bclkFall) begin
            shiftReg <= {shiftReg[2*sampleW-2:0], 1'b0};
        end
    end

endmodule

/* rtl/stereoMixer.sv */
// Pans the voice samples to left and right, sums and saturates into a registered pair
`include "audio_config.svh"

module stereoMixer (
    input  logic                                          i_aclk,
    input  logic                                          i_aresetn,
    input  logic [`AUDIO_NUM_VOICES*`AUDIO_SAMPLE_W-1:0]  i_samples,
    input  logic [`AUDIO_NUM_VOICES*4-1:0]                i_voiceCtrl,
    output audio_pkg::sample_t                            o_left,
    output audio_pkg::sample_t                            o_right
);

    localparam int numVoices = `AUDIO_NUM_VOICES;
    localparam int sampleW   = `AUDIO_SAMPLE_W;
    localparam int sumW      = sampleW + 3;    // Headroom for eight voices

    localparam logic signed [sumW-1:0] maxVal = (1 <<< (sampleW - 1)) - 1;
    localparam logic signed [sumW-1:0] minVal = -(1 <<< (sampleW - 1));

    // Mono voices feed both sides
    function automatic logic signed [sumW-1:0] sideSum(
        input logic [numVoices*sampleW-1:0] samples,
        input logic [numVoices*4-1:0]       ctrlBits,
        input logic                         rightSide
    );
        logic signed [sumW-1:0] acc;
        audio_pkg::voiceCtrl_t  ctrl;
        acc = '0;
        for (int v = 0; v < numVoices; v++) begin
            ctrl = audio_pkg::voiceCtrl_t'(ctrlBits[v*4 +: 4]);
            if (ctrl.mono || (ctrl.right == rightSide)) begin
                acc = acc + audio_pkg::sample_t'(samples[v*sampleW +: sampleW]);
            end
        end
        return acc;
    endfunction

    function automatic audio_pkg::sample_t saturate(input logic signed [sumW-1:0] sum);
        if (sum > maxVal) begin
            return {1'b0, {(sampleW - 1){1'b1}}};
        end else if (sum < minVal) begin
            return {1'b1, {(sampleW - 1){1'b0}}};
        end
        return sum[sampleW-1:0];
    endfunction

    always_ff @(posedge i_aclk) begin
        if (!i_aresetn) begin
            o_left  <= '0;
            o_right <= '0;
        end else begin
            o_left  <= saturate(sideSum(i_samples, i_voiceCtrl, 1'b0));
            o_right <= saturate(sideSum(i_samples, i_voiceCtrl, 1'b1));
        end
    end

endmodule

/* rtl/sampleFetcher.sv */
// AXI-Lite read engine fetching one sample per playing voice at each frame start
`include "audio_config.svh"

module sampleFetcher (
    input  logic                                             i_aclk,
    input  logic                                             i_aresetn,
    input  logic                                             i_frameStrobe,
    input  logic [`AUDIO_NUM_VOICES*32-1:0]                  i_voiceStart,
    input  logic [`AUDIO_NUM_VOICES*16-1:0]                  i_voiceLength,
    input  logic [`AUDIO_NUM_VOICES*4-1:0]                   i_voiceCtrl,
    output logic [`AUDIO_NUM_VOICES-1:0]                     o_voiceStop,
    output logic [`AUDIO_NUM_VOICES*16-1:0]                  o_voicePos,
    output logic [31:0]                                      o_araddr,
    output logic                                             o_arvalid,
    input  logic                                             i_arready,
    input  logic [`AUDIO_SAMPLE_W-1:0]                       i_rdata,
    input  logic                                             i_rvalid,
    output logic                                             o_rready,
    output logic [`AUDIO_NUM_VOICES*`AUDIO_SAMPLE_W-1:0]     o_samples
);

    localparam int numVoices = `AUDIO_NUM_VOICES;
    localparam int sampleW   = `AUDIO_SAMPLE_W;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_DATA,
        ST_ADVANCE
    } fetchState_t;

    fetchState_t           state;
    audio_pkg::voiceIdx_t  curVoice;
    logic [15:0]           posReg    [numVoices];
    audio_pkg::sample_t    sampleReg [numVoices];

    audio_pkg::voiceCtrl_t curCtrl;
    logic [31:0]           curStart;
    logic [15:0]           curLength;
    logic [15:0]           curPos;
    logic [15:0]           nextPos;
    logic                  lastVoice;

    assign curCtrl   = audio_pkg::voiceCtrl_t'(i_voiceCtrl[curVoice*4 +: 4]);
    assign curStart  = i_voiceStart[curVoice*32 +: 32];
    assign curLength = i_voiceLength[curVoice*16 +: 16];
    assign curPos    = posReg[curVoice];
    assign nextPos   = curPos + 16'd1;
    assign lastVoice = (curVoice == audio_pkg::voiceIdx_t'(numVoices - 1));

    always_ff @(posedge i_aclk) begin
        if (!i_aresetn) begin
            state       <= ST_IDLE;
            curVoice    <= '0;
            o_arvalid   <= 1'b0;
            o_rready    <= 1'b0;
            o_voiceStop <= '0;
            for (int v = 0; v < numVoices; v++) begin
                posReg[v]    <= '0;
                sampleReg[v] <= '0;
            end
        end else begin
            o_voiceStop <= '0;
            case (state)
                ST_IDLE: begin
                    if (i_frameStrobe) begin
                        curVoice <= '0;
                        state    <= ST_ADDR;
                    end
                end
                ST_ADDR: begin
                    if (o_arvalid) begin
                        if (i_arready) begin
                            o_arvalid <= 1'b0;
                            o_rready  <= 1'b1;
                            state     <= ST_DATA;
                        end
                    end else if (curCtrl.play) begin
                        o_arvalid <= 1'b1;
                    end else begin
                        sampleReg[curVoice] <= '0;   // Silent voice, skip it
                        if (lastVoice) begin
                            state <= ST_IDLE;
                        end else begin
                            curVoice <= curVoice + 1'b1;
                        end
                    end
                end
                ST_DATA: begin
                    if (i_rvalid) begin
                        o_rready            <= 1'b0;
                        sampleReg[curVoice] <= i_rdata;
                        state               <= ST_ADVANCE;
                    end
                end
                default: begin
                    if (nextPos >= curLength) begin
                        posReg[curVoice] <= '0;
                        if (!curCtrl.loop) begin
                            o_voiceStop[curVoice] <= 1'b1;
                            sampleReg[curVoice]   <= '0;
                        end
                    end else begin
                        posReg[curVoice] <= nextPos;
                    end
                    if (lastVoice) begin
                        state <= ST_IDLE;
                    end else begin
                        curVoice <= curVoice + 1'b1;
                        state    <= ST_ADDR;
                    end
                end
            endcase
        end
    end

    // Byte address of a 16-bit sample, held until arready
    always_ff @(posedge i_aclk) begin
        if (state == ST_ADDR && !o_arvalid) begin
            o_araddr <= curStart + {15'd0, curPos, 1'b0};
        end
    end

    always_comb begin
        for (int v = 0; v < numVoices; v++) begin
            o_voicePos[v*16 +: 16]           = posReg[v];
            o_samples[v*sampleW +: sampleW]  = sampleReg[v];
        end
    end

endmodule

/* rtl/audioRegisterBank.sv */
// APB slave holding per-voice start, length and control with status readback
`include "audio_config.svh"

module audioRegisterBank (
    input  logic                              i_aclk,
    input  logic                              i_aresetn,
    input  logic [7:0]                        i_paddr,
    input  logic                              i_psel,
    input  logic                              i_penable,
    input  logic                              i_pwrite,
    input  logic [31:0]                       i_pwdata,
    output logic [31:0]                       o_prdata,
    output logic                              o_pready,
    output logic                              o_pslverr,
    input  logic [`AUDIO_NUM_VOICES-1:0]      i_voiceStop,
    input  logic [`AUDIO_NUM_VOICES*16-1:0]   i_voicePos,
    output logic [`AUDIO_NUM_VOICES*32-1:0]   o_voiceStart,
    output logic [`AUDIO_NUM_VOICES*16-1:0]   o_voiceLength,
    output logic [`AUDIO_NUM_VOICES*4-1:0]    o_voiceCtrl
);

    localparam int numVoices = `AUDIO_NUM_VOICES;

    logic [31:0]           startReg  [numVoices];
    logic [15:0]           lengthReg [numVoices];
    audio_pkg::voiceCtrl_t ctrlReg   [numVoices];

    audio_pkg::voiceIdx_t  voiceSel;
    audio_pkg::regIdx_t    regSel;
    logic                  regValid;
    logic                  accessCycle;
    logic                  writeErr;
    logic [15:0]           posSel;
    logic [31:0]           readData;

    assign voiceSel    = i_paddr[7:5];
    assign regSel      = audio_pkg::regIdx_t'(i_paddr[3:2]);
    assign regValid    = ~i_paddr[4];                       // Indices 4 to 7 unmapped
    assign accessCycle = i_psel & i_penable & ~o_pready;    // First access cycle only
    assign writeErr    = ~regValid | (regSel == audio_pkg::REG_STATUS);
    assign posSel      = i_voicePos[voiceSel*16 +: 16];

    always_comb begin
        readData = '0;
        if (regValid) begin
            case (regSel)
                audio_pkg::REG_START:   readData = startReg[voiceSel];
                audio_pkg::REG_LENGTH:  readData = {16'd0, lengthReg[voiceSel]};
                audio_pkg::REG_CONTROL: readData = {28'd0, ctrlReg[voiceSel]};
                default:                readData = {15'd0, ctrlReg[voiceSel].play, posSel};
            endcase
        end
    end

    // Single wait state, response in the second access cycle
    always_ff @(posedge i_aclk) begin
        if (!i_aresetn) begin
            o_pready  <= 1'b0;
            o_pslverr <= 1'b0;
        end else begin
            o_pready  <= accessCycle;
            o_pslverr <= accessCycle & (i_pwrite ? writeErr : ~regValid);
        end
    end

    always_ff @(posedge i_aclk) begin
        if (accessCycle && !i_pwrite) begin
            o_prdata <= readData;
        end
    end

    always_ff @(posedge i_aclk) begin
        if (!i_aresetn) begin
            for (int v = 0; v < numVoices; v++) begin
                startReg[v]  <= '0;
                lengthReg[v] <= '0;
                ctrlReg[v]   <= '0;
            end
        end else begin
            for (int v = 0; v < numVoices; v++) begin
                if (i_voiceStop[v]) begin
                    ctrlReg[v].play <= 1'b0;    // End of a one-shot voice
                end
            end
            // Later assignment, so a CPU write beats a stop in the same cycle
            if (accessCycle && i_pwrite && !writeErr) begin
                case (regSel)
                    audio_pkg::REG_START:  startReg[voiceSel]  <= {i_pwdata[31:1], 1'b0};
                    audio_pkg::REG_LENGTH: lengthReg[voiceSel] <= i_pwdata[15:0];
                    default:               ctrlReg[voiceSel]   <= audio_pkg::voiceCtrl_t'(i_pwdata[3:0]);
                endcase
            end
        end
    end

    always_comb begin
        for (int v = 0; v < numVoices; v++) begin
            o_voiceStart[v*32 +: 32]  = startReg[v];
            o_voiceLength[v*16 +: 16] = lengthReg[v];
            o_voiceCtrl[v*4 +: 4]     = ctrlReg[v];
        end
    end

endmodule

/* rtl/audio_pkg.sv */
// Shared voice, register and sample types of the audio engine
`include "audio_config.svh"

package audio_pkg;

    // Voice number within the register map
    typedef logic [2:0] voiceIdx_t;

    // Register index inside one voice, paddr[3:2]
    typedef enum logic [1:0] {
        REG_START   = 2'd0,
        REG_LENGTH  = 2'd1,
        REG_CONTROL = 2'd2,
        REG_STATUS  = 2'd3
    } regIdx_t;

    // Play in bit 3, right in bit 0
    typedef struct packed {
        logic play;
        logic loop;
        logic mono;
        logic right;
    } voiceCtrl_t;

    typedef logic signed [`AUDIO_SAMPLE_W-1:0] sample_t;

endpackage

/* rtl/audio_config.svh */
// Audio engine build constants for voice count, sample width and bit-clock rate
`ifndef AUDIO_CONFIG_SVH
`define AUDIO_CONFIG_SVH

// Voices mixed per frame
`define AUDIO_NUM_VOICES 8

// Bits per sample and per I2S word
`define AUDIO_SAMPLE_W 16

// aclk cycles per bit-clock half period
// 32 bit clocks per frame gives 256 aclk cycles per frame
`define AUDIO_BCLK_DIV 4

`endif
